// ==== htif_bridge.f ====
src/htif_pkg.sv
src/htif_fifo.sv
src/htif_write_port.sv
src/htif_read_port.sv
src/htif_bridge.sv
tb/tb_clock_gen.sv
tb/htif_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module htif_bridge_tb -f htif_bridge.f -o sim_htif_bridge

out=$(./obj_dir/sim_htif_bridge)
echo "$out"

if echo "$out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
exit 1

// ==== src/htif_bridge.sv ====
`timescale 1ns/1ns

module htif_bridge (
  input  logic                    host_clk,
  input  logic                    reset,
  // aw channel
  input  htif_pkg::axil_addr_t    aw,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  // w channel
  input  htif_pkg::axil_wdata_t   w,
  input  logic                    w_valid,
  output logic                    w_ready,
  // b channel
  output logic [1:0]              b_resp,
  output logic                    b_valid,
  input  logic                    b_ready,
  // ar channel
  input  htif_pkg::axil_addr_t    ar,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  // r channel
  output htif_pkg::axil_rdata_t   r,
  output logic                    r_valid,
  input  logic                    r_ready,
  // stream into the chip
  output logic                    host_in_valid,
  input  logic                    host_in_ready,
  output htif_pkg::host_word_t    host_in_data,
  // stream out of the chip
  input  logic                    host_out_valid,
  output logic                    host_out_ready,
  input  htif_pkg::host_word_t    host_out_data,
  // chip reset pulse
  output logic                    cpu_reset
);

  // inbound queue, bus to chip
  logic in_push;
  htif_pkg::host_word_t in_data;
  logic in_full;
  logic in_empty;

  // outbound queue, chip to bus
  logic out_pop;
  htif_pkg::host_word_t out_head;
  logic out_full;
  logic [htif_pkg::count_width-1:0] out_count;

  assign host_in_valid = !in_empty;
  assign host_out_ready = !out_full;

  htif_write_port u_write_port (
    .host_clk  (host_clk),
    .reset     (reset),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b_valid   (b_valid),
    .b_resp    (b_resp),
    .b_ready   (b_ready),
    .in_full   (in_full),
    .in_push   (in_push),
    .in_data   (in_data),
    .cpu_reset (cpu_reset)
  );

  htif_read_port u_read_port (
    .host_clk  (host_clk),
    .reset     (reset),
    .ar        (ar),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .out_head  (out_head),
    .out_count (out_count),
    .out_pop   (out_pop)
  );

  // drained by the chip on a stream handshake
  htif_fifo in_fifo (
    .host_clk (host_clk),
    .reset    (reset),
    .push     (in_push),
    .pop      (host_in_valid && host_in_ready),
    .din      (in_data),
    .dout     (host_in_data),
    .full     (in_full),
    .empty    (in_empty),
    .count    ()
  );

  // filled by the chip, drained by data reads
  htif_fifo out_fifo (
    .host_clk (host_clk),
    .reset    (reset),
    .push     (host_out_valid && host_out_ready),
    .pop      (out_pop),
    .din      (host_out_data),
    .dout     (out_head),
    .full     (out_full),
    .empty    (),
    .count    (out_count)
  );

endmodule

// ==== src/htif_fifo.sv ====
`timescale 1ns/1ns

module htif_fifo (
  input  logic                               host_clk,
  input  logic                               reset,
  input  logic                               push,
  input  logic                               pop,
  input  htif_pkg::host_word_t               din,
  output htif_pkg::host_word_t               dout,
  output logic                               full,
  output logic                               empty,
  output logic [htif_pkg::count_width-1:0]   count
);

  // word storage
  htif_pkg::host_word_t mem [htif_pkg::fifo_depth];

  // pointers wrap at the power-of-two depth
  logic [$clog2(htif_pkg::fifo_depth)-1:0] wr_ptr;
  logic [$clog2(htif_pkg::fifo_depth)-1:0] rd_ptr;

  logic [htif_pkg::count_width-1:0] count_next;
  logic do_push;
  logic do_pop;

  // push while full only goes through with a pop in the same cycle
  assign do_push = push && (!full || pop);
  // pop on empty is dropped
  assign do_pop = pop && !empty;

  // head of queue is undefined when empty
  assign dout = mem[rd_ptr];

  // occupancy after this cycle
  always_comb
  begin
    case ({do_push, do_pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // write side of the ram
  always_ff @(posedge host_clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers, count and flags
  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      full <= 1'b0;
      empty <= 1'b1;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      // flags follow the next count so they stay registered
      full <= (count_next == htif_pkg::count_width'(htif_pkg::fifo_depth));
      empty <= (count_next == '0);
    end
  end

  // occupancy never runs past the depth
  a_count_bound: assert property (
    @(posedge host_clk) disable iff (reset)
    count <= htif_pkg::count_width'(htif_pkg::fifo_depth)
  ) else $error("htif_fifo count above depth");

  // empty flag tracks the counter
  a_empty_match: assert property (
    @(posedge host_clk) disable iff (reset)
    empty == (count == '0)
  ) else $error("htif_fifo empty flag out of step with count");

endmodule

// ==== src/htif_pkg.sv ====
package htif_pkg;

  // bus and queue word sizes
  localparam int data_width = 32;
  localparam int addr_width = 32;

  // queue depth and occupancy width, count runs 0..fifo_depth
  localparam int fifo_depth = 32;
  localparam int count_width = 6;

  // register index comes from address bits 6:2
  localparam int reg_width = 5;

  // read side register map
  localparam logic [reg_width-1:0] reg_count_rd = 5'd0;
  localparam logic [reg_width-1:0] reg_data_rd = 5'd1;

  // write side register map
  localparam logic [reg_width-1:0] reg_data_wr = 5'd0;
  localparam logic [reg_width-1:0] reg_reset_wr = 5'd31;

  // axi response codes, only okay is ever returned
  localparam logic [1:0] resp_okay = 2'b00;

  // aw and ar payload
  typedef struct packed {
    logic [addr_width-1:0] addr;
  } axil_addr_t;

  // w payload
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [data_width/8-1:0] strb;
  } axil_wdata_t;

  // r payload
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [1:0] resp;
  } axil_rdata_t;

  // one queue entry, also the stream word to and from the chip
  typedef logic [data_width-1:0] host_word_t;

endpackage

// ==== src/htif_read_port.sv ====
`timescale 1ns/1ns

module htif_read_port (
  input  logic                              host_clk,
  input  logic                              reset,
  input  htif_pkg::axil_addr_t              ar,
  input  logic                              ar_valid,
  output logic                              ar_ready,
  output htif_pkg::axil_rdata_t             r,
  output logic                              r_valid,
  input  logic                              r_ready,
  input  htif_pkg::host_word_t              out_head,
  input  logic [htif_pkg::count_width-1:0]  out_count,
  output logic                              out_pop
);

  typedef enum logic {
    rd_idle,
    rd_resp
  } rd_state_t;

  rd_state_t state;

  logic [htif_pkg::reg_width-1:0] ar_index;
  logic [htif_pkg::reg_width-1:0] rd_index;
  // queue had a word when the address was taken
  logic rd_nonempty;
  htif_pkg::host_word_t rd_sel;
  htif_pkg::host_word_t rd_word;
  logic ar_take;

  assign ar_index = ar.addr[2 +: htif_pkg::reg_width];
  assign ar_ready = (state == rd_idle);
  assign ar_take = ar_ready && ar_valid;
  assign r_valid = (state == rd_resp);

  // data frozen in the register, stable under back-pressure
  assign r.data = rd_word;
  assign r.resp = htif_pkg::resp_okay;

  // pop only for a data read that saw a word at acceptance
  assign out_pop = r_valid && r_ready && (rd_index == htif_pkg::reg_data_rd) && rd_nonempty;

  // register select, unmapped reads as zero
  always_comb
  begin
    rd_sel = '0;
    case (ar_index)
      htif_pkg::reg_count_rd: rd_sel[htif_pkg::count_width-1:0] = out_count;
      htif_pkg::reg_data_rd:  rd_sel = out_head;
      default:                rd_sel = '0;
    endcase
  end

  // control
  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      state <= rd_idle;
    end
    else if (ar_take)
    begin
      state <= rd_resp;
    end
    else if (r_valid && r_ready)
    begin
      state <= rd_idle;
    end
  end

  // capture on ar acceptance
  always_ff @(posedge host_clk)
  begin
    if (ar_take)
    begin
      rd_index <= ar_index;
      rd_word <= rd_sel;
      rd_nonempty <= (out_count != '0);
    end
  end

  // r payload stays put while the master stalls
  a_r_stable: assert property (
    @(posedge host_clk) disable iff (reset)
    (r_valid && !r_ready) |=> (r_valid && $stable(r))
  ) else $error("r changed under back-pressure");

endmodule

// ==== src/htif_write_port.sv ====
`timescale 1ns/1ns

module htif_write_port (
  input  logic                      host_clk,
  input  logic                      reset,
  input  htif_pkg::axil_addr_t      aw,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  htif_pkg::axil_wdata_t     w,
  input  logic                      w_valid,
  output logic                      w_ready,
  output logic                      b_valid,
  output logic [1:0]                b_resp,
  input  logic                      b_ready,
  input  logic                      in_full,
  output logic                      in_push,
  output htif_pkg::host_word_t      in_data,
  output logic                      cpu_reset
);

  typedef enum logic [1:0] {
    wr_idle,
    wr_write,
    wr_ack
  } wr_state_t;

  wr_state_t state;

  // index and data held from the idle cycle
  logic [htif_pkg::reg_width-1:0] wr_index;
  htif_pkg::host_word_t wr_data;

  // the single cycle where aw and w are taken
  logic accept;
  logic is_data;

  assign is_data = (wr_index == htif_pkg::reg_data_wr);

  // only the data register waits on the inbound queue
  assign accept = (state == wr_write) && (!in_full || !is_data);

  assign aw_ready = accept;
  assign w_ready = accept;

  // push or reset pulse land in the accept cycle
  assign in_push = accept && is_data;
  assign cpu_reset = accept && (wr_index == htif_pkg::reg_reset_wr);
  assign in_data = wr_data;

  // response held until the master takes it
  assign b_valid = (state == wr_ack);
  assign b_resp = htif_pkg::resp_okay;

  // control
  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      state <= wr_idle;
    end
    else
    begin
      case (state)
        wr_idle:
        begin
          // need both address and data before starting
          if (aw_valid && w_valid)
          begin
            state <= wr_write;
          end
        end
        wr_write:
        begin
          if (accept)
          begin
            state <= wr_ack;
          end
        end
        wr_ack:
        begin
          if (b_ready)
          begin
            state <= wr_idle;
          end
        end
        default:
        begin
          state <= wr_idle;
        end
      endcase
    end
  end

  // payload capture, strobes ignored since every register is a whole word
  always_ff @(posedge host_clk)
  begin
    if (state == wr_idle && aw_valid && w_valid)
    begin
      wr_index <= aw.addr[2 +: htif_pkg::reg_width];
      wr_data <= w.data;
    end
  end

  // b_valid held until the handshake
  a_b_hold: assert property (
    @(posedge host_clk) disable iff (reset)
    (b_valid && !b_ready) |=> b_valid
  ) else $error("b_valid dropped before b_ready");

  // inbound queue never pushed while it reports full
  a_no_push_full: assert property (
    @(posedge host_clk) disable iff (reset)
    in_push |-> !in_full
  ) else $error("push into a full inbound queue");

endmodule

// ==== tb/htif_bridge_tb.sv ====
`timescale 1ns/1ns

module htif_bridge_tb;

  typedef enum logic [2:0] {
    op_write, op_write_stall, op_read_reg, op_read_data, op_push_out, op_pop_in, op_out_full
  } op_t;

  // one table row applied reps times
  typedef struct packed {
    op_t op;
    logic [htif_pkg::reg_width-1:0] index;
    htif_pkg::host_word_t data;
    logic use_lfsr;
    logic [7:0] reps;
    htif_pkg::host_word_t expected;
  } row_t;

  typedef enum logic [2:0] {
    wait_accept, wait_bresp, wait_ar, wait_r, wait_in, wait_out
  } wait_t;

  logic host_clk;
  logic reset;
  htif_pkg::axil_addr_t aw;
  logic aw_valid;
  logic aw_ready;
  htif_pkg::axil_wdata_t w;
  logic w_valid;
  logic w_ready;
  logic [1:0] b_resp;
  logic b_valid;
  logic b_ready;
  htif_pkg::axil_addr_t ar;
  logic ar_valid;
  logic ar_ready;
  htif_pkg::axil_rdata_t r;
  logic r_valid;
  logic r_ready;
  logic host_in_valid;
  logic host_in_ready;
  htif_pkg::host_word_t host_in_data;
  logic host_out_valid;
  logic host_out_ready;
  htif_pkg::host_word_t host_out_data;
  logic cpu_reset;

  // reference queues in order of arrival
  htif_pkg::host_word_t in_q[$];
  htif_pkg::host_word_t out_q[$];
  row_t rows[$];
  logic [15:0] lfsr_state;
  int checks;
  int errors;
  logic timed_out;

  tb_clock_gen u_clock_gen (
    .host_clk (host_clk),
    .reset    (reset)
  );

  htif_bridge DUT (
    .host_clk       (host_clk),
    .reset          (reset),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b_resp         (b_resp),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .ar             (ar),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .r              (r),
    .r_valid        (r_valid),
    .r_ready        (r_ready),
    .host_in_valid  (host_in_valid),
    .host_in_ready  (host_in_ready),
    .host_in_data   (host_in_data),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_data  (host_out_data),
    .cpu_reset      (cpu_reset)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic rand_word(output htif_pkg::host_word_t word);
    word = '0;
    for (int b = 0; b < htif_pkg::data_width; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      word = {word[htif_pkg::data_width-2:0], lfsr_state[0]};
    end
  endtask

  // register index sits at address bits 6:2
  function automatic htif_pkg::axil_addr_t reg_addr(input logic [htif_pkg::reg_width-1:0] idx);
    htif_pkg::axil_addr_t a;
    a.addr = {{(htif_pkg::addr_width-htif_pkg::reg_width-2){1'b0}}, idx, 2'b00};
    return a;
  endfunction

  task automatic check_word(input string name, input htif_pkg::host_word_t got,
                            input htif_pkg::host_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [htif_pkg::count_width-1:0] got,
                             input logic [htif_pkg::count_width-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic dut_flag(input wait_t sel);
    case (sel)
      wait_accept: return aw_ready && w_ready;
      wait_bresp:  return b_valid;
      wait_ar:     return ar_ready;
      wait_r:      return r_valid;
      wait_in:     return host_in_valid;
      default:     return host_out_ready;
    endcase
  endfunction

  // samples at the falling edge and returns there once the flag is high
  task automatic wait_for(input wait_t sel, input string what);
    int n;
    n = 0;
    @(negedge host_clk);
    while (!timed_out && !dut_flag(sel))
    begin
      if (n == 100)
      begin
        $display("timeout after 100 cycles waiting for %s", what);
        timed_out = 1'b1;
      end
      else
      begin
        n++;
        @(negedge host_clk);
      end
    end
  endtask

  // back to the drive point just after the rising edge
  task automatic to_drive_point();
    @(posedge host_clk);
    #1;
  endtask

  task automatic pop_in();
    htif_pkg::host_word_t exp;
    host_in_ready = 1'b1;
    wait_for(wait_in, "host_in_valid");
    if (!timed_out && in_q.size() == 0)
    begin
      errors++;
      $display("inbound word arrived with no write left to match it");
    end
    else if (!timed_out)
    begin
      exp = in_q.pop_front();
      check_word("host_in_data", host_in_data, exp);
    end
    to_drive_point();
    host_in_ready = 1'b0;
  endtask

  task automatic push_out(input htif_pkg::host_word_t data);
    host_out_data = data;
    host_out_valid = 1'b1;
    wait_for(wait_out, "host_out_ready");
    to_drive_point();
    host_out_valid = 1'b0;
    out_q.push_back(data);
  endtask

  task automatic bus_write(input logic [htif_pkg::reg_width-1:0] idx,
                           input htif_pkg::host_word_t data, input logic stall);
    aw = reg_addr(idx);
    w.data = data;
    w.strb = '1;
    aw_valid = 1'b1;
    w_valid = 1'b1;
    if (stall)
    begin
      // inbound queue full so the write hangs
      repeat (8)
      begin
        @(negedge host_clk);
        check_bit("aw_ready", aw_ready, 1'b0);
        check_bit("w_ready", w_ready, 1'b0);
        check_bit("b_valid", b_valid, 1'b0);
      end
      to_drive_point();
      pop_in();
    end
    wait_for(wait_accept, "aw_ready and w_ready");
    // reset pulse lands in the accept cycle only
    check_bit("cpu_reset", cpu_reset, idx == htif_pkg::reg_reset_wr);
    if (idx == htif_pkg::reg_data_wr)
    begin
      in_q.push_back(data);
    end
    to_drive_point();
    aw_valid = 1'b0;
    w_valid = 1'b0;
    b_ready = 1'b1;
    wait_for(wait_bresp, "b_valid");
    check_resp("b_resp", b_resp, htif_pkg::resp_okay);
    check_bit("cpu_reset", cpu_reset, 1'b0);
    check_bit("host_in_valid", host_in_valid, in_q.size() != 0);
    to_drive_point();
    b_ready = 1'b0;
  endtask

  task automatic bus_read(input logic [htif_pkg::reg_width-1:0] idx,
                          output htif_pkg::host_word_t word);
    ar = reg_addr(idx);
    ar_valid = 1'b1;
    wait_for(wait_ar, "ar_ready");
    to_drive_point();
    ar_valid = 1'b0;
    wait_for(wait_r, "r_valid");
    word = r.data;
    check_resp("r.resp", r.resp, htif_pkg::resp_okay);
    // data has to hold over one stalled cycle
    to_drive_point();
    @(negedge host_clk);
    check_word("r.data held", r.data, word);
    to_drive_point();
    r_ready = 1'b1;
    to_drive_point();
    r_ready = 1'b0;
  endtask

  task automatic add_row(input op_t op, input logic [htif_pkg::reg_width-1:0] idx,
                         input htif_pkg::host_word_t data, input logic use_lfsr,
                         input logic [7:0] reps, input htif_pkg::host_word_t expected);
    rows.push_back({op, idx, data, use_lfsr, reps, expected});
  endtask

  task automatic apply_row(input row_t row);
    htif_pkg::host_word_t d;
    htif_pkg::host_word_t got;
    d = row.data;
    if (row.use_lfsr)
    begin
      rand_word(d);
    end
    case (row.op)
      op_write:       bus_write(row.index, d, 1'b0);
      op_write_stall: bus_write(row.index, d, 1'b1);
      op_push_out:    push_out(d);
      op_pop_in:      pop_in();
      op_read_data:
      begin
        bus_read(htif_pkg::reg_data_rd, got);
        check_word("r.data", got, out_q.size() != 0 ? out_q.pop_front() : 'x);
      end
      op_read_reg:
      begin
        bus_read(row.index, got);
        if (row.index == htif_pkg::reg_count_rd)
        begin
          check_count("count", got[htif_pkg::count_width-1:0],
                      row.expected[htif_pkg::count_width-1:0]);
        end
        check_word("r.data", got, row.expected);
      end
      default:
      begin
        @(negedge host_clk);
        check_bit("host_out_ready", host_out_ready, row.expected[0]);
        to_drive_point();
      end
    endcase
  endtask

  initial
  begin
    int n;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    host_in_ready = 1'b0;
    host_out_valid = 1'b0;
    host_out_data = '0;
    lfsr_state = 16'd44;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;

    // op, index, data, lfsr, reps, expected
    add_row(op_write,       5'd0,  32'h0,         1'b1, 8'd4,  32'h0);
    add_row(op_pop_in,      5'd0,  32'h0,         1'b0, 8'd4,  32'h0);
    add_row(op_push_out,    5'd0,  32'h0,         1'b1, 8'd3,  32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd3);
    add_row(op_read_data,   5'd1,  32'h0,         1'b0, 8'd1,  32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd2);
    add_row(op_read_data,   5'd1,  32'h0,         1'b0, 8'd2,  32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd0);
    add_row(op_write,       5'd31, 32'h0,         1'b0, 8'd1,  32'h0);
    add_row(op_write,       5'd7,  32'h5a5a_0f0f, 1'b0, 8'd1,  32'h0);
    add_row(op_read_reg,    5'd9,  32'h0,         1'b0, 8'd1,  32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd0);
    // inbound back-pressure where 32 fill the queue and the 33rd stalls
    add_row(op_write,       5'd0,  32'h0,         1'b1, 8'd32, 32'h0);
    add_row(op_write_stall, 5'd0,  32'h0,         1'b1, 8'd1,  32'h0);
    add_row(op_pop_in,      5'd0,  32'h0,         1'b0, 8'd32, 32'h0);
    // outbound back-pressure
    add_row(op_push_out,    5'd0,  32'h0,         1'b1, 8'd32, 32'h0);
    add_row(op_out_full,    5'd0,  32'h0,         1'b0, 8'd1,  32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd32);
    add_row(op_read_data,   5'd1,  32'h0,         1'b0, 8'd32, 32'h0);
    add_row(op_read_reg,    5'd0,  32'h0,         1'b0, 8'd1,  32'd0);

    n = 0;
    while (reset !== 1'b0 && !timed_out)
    begin
      if (n == 100)
      begin
        $display("timeout after 100 cycles waiting for reset to release");
        timed_out = 1'b1;
      end
      else
      begin
        n++;
        @(posedge host_clk);
      end
    end
    #1;

    // idle outputs straight after reset
    @(negedge host_clk);
    check_bit("ar_ready", ar_ready, 1'b1);
    check_bit("host_out_ready", host_out_ready, 1'b1);
    check_bit("aw_ready", aw_ready, 1'b0);
    check_bit("w_ready", w_ready, 1'b0);
    check_bit("b_valid", b_valid, 1'b0);
    check_bit("r_valid", r_valid, 1'b0);
    check_bit("host_in_valid", host_in_valid, 1'b0);
    check_bit("cpu_reset", cpu_reset, 1'b0);
    to_drive_point();

    for (int i = 0; i < rows.size() && !timed_out; i++)
    begin
      for (int k = 0; k < int'(rows[i].reps) && !timed_out; k++)
      begin
        apply_row(rows[i]);
      end
    end

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic host_clk,
  output logic reset
);

  // 40 ns period
  initial
  begin
    host_clk = 1'b0;
    forever #20 host_clk = ~host_clk;
  end

  // reset held over three rising edges, released just after the third
  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge host_clk);
    #1 reset = 1'b0;
  end

endmodule
